//--- Makefile
# Verilator build and run of the HDC encoder testbench

VERILATOR ?= verilator
TOP       ?= tb_hdc_encoder
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= === PASS ===

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# Pass only when the pass line shows up in the simulation output
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- common/hdc_pkg.sv
`default_nettype none

package hdc_pkg;

  // -------------------------------------------------------------------
  // Datapath widths
  // -------------------------------------------------------------------
  localparam int unsigned HV_DIM     = 128;
  localparam int unsigned IM_ADDR_W  = 10;
  localparam int unsigned SET_W      = 3;
  localparam int unsigned INDEX_W    = 7;
  localparam int unsigned SEED_W     = 32;
  localparam int unsigned NUM_SETS   = 8;
  localparam int unsigned BUND_CNT_W = 8;

  // -------------------------------------------------------------------
  // Item memory seeds
  // -------------------------------------------------------------------
  localparam logic [SEED_W-1:0] CIM_BASE_SEED = 32'd621635317;

  // Set 7 first, set 0 last
  localparam logic [NUM_SETS-1:0][SEED_W-1:0] ORTHO_SEEDS = {
    32'd2535149661,
    32'd2525737372,
    32'd4032445525,
    32'd811160829,
    32'd2850820469,
    32'd3074702788,
    32'd2391206478,
    32'd1103779247
  };

  // -------------------------------------------------------------------
  // Types
  // -------------------------------------------------------------------
  typedef logic [HV_DIM-1:0] hv_t;

  // Orthogonal view of the address
  typedef struct packed {
    logic [SET_W-1:0]   set;
    logic [INDEX_W-1:0] index;
  } im_item_t;

  // Continuous view of the address
  typedef struct packed {
    logic [IM_ADDR_W-1:0] level;
  } im_level_t;

  typedef union packed {
    im_item_t  item;
    im_level_t level;
  } im_addr_u;

  // One request beat from the outside
  typedef struct packed {
    logic     valid;
    logic     last;
    logic     cim_a;
    logic     cim_b;
    im_addr_u addr_a;
    im_addr_u addr_b;
  } enc_req_t;

  // Item memory output towards the bundler
  typedef struct packed {
    logic valid;
    hv_t  hv;
  } im_beat_t;

endpackage

`default_nettype wire

//--- item_memory/item_mem_port.sv
`default_nettype none

module item_mem_port (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  input  logic              cim_i,
  input  hdc_pkg::im_addr_u addr_i,
  output hdc_pkg::im_beat_t beat_o
);

  // -------------------------------------------------------------------
  // Orthogonal decode
  // -------------------------------------------------------------------
  logic [hdc_pkg::SEED_W-1:0]   ortho_seed;
  hdc_pkg::hv_t                 ortho_base;
  logic [2*hdc_pkg::HV_DIM-1:0] ortho_dbl;
  hdc_pkg::hv_t                 ortho_hv;

  // Seed of the selected set, tiled across the full HV
  assign ortho_seed = hdc_pkg::ORTHO_SEEDS[addr_i.item.set];
  assign ortho_base = {(hdc_pkg::HV_DIM / hdc_pkg::SEED_W){ortho_seed}};

  // Rotate left by index, upper half of the doubled vector
  assign ortho_dbl = {ortho_base, ortho_base} << addr_i.item.index;
  assign ortho_hv  = ortho_dbl[2*hdc_pkg::HV_DIM-1 -: hdc_pkg::HV_DIM];

  // -------------------------------------------------------------------
  // Continuous (CiM) decode
  // -------------------------------------------------------------------
  hdc_pkg::hv_t                  cim_base;
  logic [hdc_pkg::IM_ADDR_W-1:0] flip_cnt;
  hdc_pkg::hv_t                  flip_mask;
  hdc_pkg::hv_t                  cim_hv;

  assign cim_base = {(hdc_pkg::HV_DIM / hdc_pkg::SEED_W){hdc_pkg::CIM_BASE_SEED}};

  // One more flipped bit every 8 levels
  assign flip_cnt  = addr_i.level.level >> 3;
  assign flip_mask = ~(hdc_pkg::hv_t'('1) << flip_cnt);
  assign cim_hv    = cim_base ^ flip_mask;

  // -------------------------------------------------------------------
  // Output register
  // -------------------------------------------------------------------
  hdc_pkg::hv_t hv_d;
  hdc_pkg::hv_t hv_q;
  logic         valid_q;

  assign hv_d = cim_i ? cim_hv : ortho_hv;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on a real request
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      hv_q <= hv_d;
    end
  end

  assign beat_o = '{valid: valid_q, hv: hv_q};

  // A valid beat always carries a known HV
  a_beat_known : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    beat_o.valid |-> !$isunknown(beat_o.hv)
  ) else $error("item_mem_port: valid beat with unknown HV");

endmodule

`default_nettype wire

//--- sim.f
+incdir+verif
common/hdc_pkg.sv
item_memory/item_mem_port.sv
verilog/hv_bundler.sv
verilog/hdc_encoder_top.sv
verif/tb_hdc_encoder.sv

//--- verif/hdc_cases.txt
# B valid last cim_a cim_b addr_a addr_b [expected query HV in hex, on valid last beats]
# G n idles n cycles, R idles 0 to 2 random cycles; orthogonal address is set*128+index
# Orthogonal mode, one beat per bundle
B 1 1 0 0 0 128 CF4CBFE1CF4CBFE1CF4CBFE1CF4CBFE1
R
B 1 1 0 0 257 384 C7646AFCC7646AFCC7646AFCC7646AFC
R
B 1 1 0 0 639 641 7898D2D57898D2D57898D2D57898D2D5
R
B 1 1 0 0 1023 895 80C870E080C870E080C870E080C870E0
R
B 1 1 0 0 129 127 BDE8FE4ABDE8FE4ABDE8FE4ABDE8FE4A
R
B 1 1 0 0 448 384 00000000000000000000000000000000
G 3
# CiM mode, one beat per bundle
B 1 1 1 1 0 8 00000000000000000000000000000001
R
B 1 1 1 1 512 1023 7FFFFFFFFFFFFFFF0000000000000000
R
B 1 1 1 1 8 512 0000000000000000FFFFFFFFFFFFFFFE
R
B 1 1 1 1 1023 0 7FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
R
B 1 1 1 1 7 0 00000000000000000000000000000000
R
# Mixed, port A in CiM mode and port B orthogonal
B 1 1 1 0 0 0 64C7335A64C7335A64C7335A64C7335A
R
B 1 1 1 0 256 257 4B851D7C4B851D7C4B851D7CB47AE283
R
B 1 1 1 0 1023 512 6AABCDF7EAABCDF7EAABCDF7EAABCDF7
G 2
# Three beats, majority of two or more
B 1 0 1 1 0 512
B 1 0 1 1 256 768
B 1 1 1 1 512 1016 00000000FFFFFFFFFFFFFFFF00000000
R
# Four beats, ties of two give zero
B 1 0 1 1 0 512
B 1 0 1 1 0 768
B 1 0 1 1 256 1016
B 1 1 1 1 768 1016 0000000000000000FFFFFFFF00000000
R
# Three beats with an invalid last and an idle cycle inside
B 1 0 0 0 0 128
B 0 1 0 0 5 9
G 1
B 1 0 0 0 0 128
B 1 1 1 1 0 8 CF4CBFE1CF4CBFE1CF4CBFE1CF4CBFE1
G 3
# Back-to-back bundles
B 1 1 0 0 0 128 CF4CBFE1CF4CBFE1CF4CBFE1CF4CBFE1
B 1 0 1 1 0 512
B 1 0 1 1 256 768
B 1 1 1 1 512 1016 00000000FFFFFFFFFFFFFFFF00000000
B 1 1 0 0 257 384 C7646AFCC7646AFCC7646AFCC7646AFC
B 1 0 1 1 0 512
B 1 0 1 1 0 768
B 1 0 1 1 256 1016
B 1 1 1 1 768 1016 0000000000000000FFFFFFFF00000000
B 1 1 1 1 0 8 00000000000000000000000000000001
B 1 1 1 0 256 257 4B851D7C4B851D7C4B851D7CB47AE283
G 4

//--- verif/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Mismatch counters, one per kind of result
int value_errs  = 0;
int timing_errs = 0;

// Query HV against the majority value from the case file
task automatic check_qhv(input hdc_pkg::hv_t exp_hv, input hdc_pkg::hv_t act_hv);
  if (act_hv !== exp_hv) begin
    value_errs++;
    $display("** Error at %0t: query HV expected %h, got %h",
             $time, exp_hv, act_hv);
  end
endtask

// Cycle on which the query pulse was seen
task automatic check_cycle(input int exp_cyc, input int act_cyc);
  if (act_cyc != exp_cyc) begin
    timing_errs++;
    $display("** Error at %0t: query pulse on cycle %0d, expected cycle %0d",
             $time, act_cyc, exp_cyc);
  end
endtask

`endif

//--- verif/tb_hdc_encoder.sv
`default_nettype none

module tb_hdc_encoder;

  localparam int RESET_CYCLES  = 16;
  localparam int DRAIN_TIMEOUT = 50;

  logic              clk;
  logic              arst_n;
  hdc_pkg::enc_req_t req;
  hdc_pkg::hv_t      qhv;
  logic              qhv_valid;

  // Expected results in bundle order, with the cycle each one is due
  hdc_pkg::hv_t exp_hv_q[$];
  int           exp_due_q[$];
  int           cyc = 0;
  int           seed = 32'h2904_cedd;
  int           stray_errs = 0;
  int           run_errs = 0;

  `include "tb_checks.svh"

  hdc_encoder_top u_dut (
    .clk_i       ( clk       ),
    .arst_n_i    ( arst_n    ),
    .req_i       ( req       ),
    .qhv_o       ( qhv       ),
    .qhv_valid_o ( qhv_valid )
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ---------------------------------------------------------------------
  // Stimulus
  // ---------------------------------------------------------------------
  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      req.valid <= 1'b0;
      req.last  <= 1'b0;
    end
  endtask

  task automatic drive_beat(input hdc_pkg::enc_req_t beat, input hdc_pkg::hv_t exp_hv);
    @(posedge clk);
    req <= beat;
    // Request edge is the next one, pulse set two edges later, seen one edge after
    if (beat.valid && beat.last) begin
      exp_hv_q.push_back(exp_hv);
      exp_due_q.push_back(cyc + 3);
    end
  endtask

  task automatic run_cases(input int fd);
    logic [7:0]        kind;
    logic [8*256-1:0]  rest;
    int                n;
    int                valid_f, last_f, cim_a_f, cim_b_f, addr_a_f, addr_b_f;
    int                gap;
    hdc_pkg::enc_req_t beat;
    hdc_pkg::hv_t      exp_hv;
    bit                done;
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", kind);
      exp_hv = '0;
      if (n != 1) begin
        done = 1'b1;
      end else if (kind == "#") begin
        n = $fgets(rest, fd);
      end else if (kind == "G") begin
        n = $fscanf(fd, "%d", gap);
        drive_idle(gap);
      end else if (kind == "R") begin
        gap = $unsigned($random(seed)) % 3;
        drive_idle(gap);
      end else if (kind == "B") begin
        n = $fscanf(fd, "%d %d %d %d %d %d", valid_f, last_f, cim_a_f, cim_b_f,
                    addr_a_f, addr_b_f);
        beat.valid  = (valid_f != 0);
        beat.last   = (last_f != 0);
        beat.cim_a  = (cim_a_f != 0);
        beat.cim_b  = (cim_b_f != 0);
        beat.addr_a = hdc_pkg::im_addr_u'(addr_a_f[hdc_pkg::IM_ADDR_W-1:0]);
        beat.addr_b = hdc_pkg::im_addr_u'(addr_b_f[hdc_pkg::IM_ADDR_W-1:0]);
        if (beat.valid && beat.last) begin
          n = $fscanf(fd, "%h", exp_hv);
        end
        drive_beat(beat, exp_hv);
      end else begin
        $display("Case file holds a line of unknown kind, reading stopped");
        run_errs++;
        done = 1'b1;
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // Result monitor
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    if (qhv_valid === 1'b1) begin
      if (exp_hv_q.size() == 0) begin
        stray_errs++;
        $display("Query pulse at time %0t without a pending last beat", $time);
      end else begin
        check_qhv(exp_hv_q.pop_front(), qhv);
        check_cycle(exp_due_q.pop_front(), cyc);
      end
    end else if (qhv_valid !== 1'b0) begin
      stray_errs++;
      $display("Query valid is unknown at time %0t", $time);
    end
  end

  initial begin : main_seq
    int fd;
    int wait_cycles;
    req    <= '0;
    arst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    drive_idle(2);

    fd = $fopen("verif/hdc_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file verif/hdc_cases.txt");
      run_errs++;
    end else begin
      run_cases(fd);
      $fclose(fd);
    end
    drive_idle(1);

    wait_cycles = 0;
    while (exp_hv_q.size() != 0 && wait_cycles < DRAIN_TIMEOUT) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (exp_hv_q.size() != 0) begin
      $display("Timed out after %0d cycles, %0d query results never arrived",
               wait_cycles, exp_hv_q.size());
      run_errs++;
    end
    // A few quiet cycles to catch stray pulses
    drive_idle(4);

    $display("Errors: value %0d, timing %0d, stray pulse %0d, run %0d",
             value_errs, timing_errs, stray_errs, run_errs);
    if (value_errs + timing_errs + stray_errs + run_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/hdc_encoder_top.sv
`default_nettype none

module hdc_encoder_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  hdc_pkg::enc_req_t req_i,
  output hdc_pkg::hv_t      qhv_o,
  output logic              qhv_valid_o
);

  // -------------------------------------------------------------------
  // Item memory ports
  // -------------------------------------------------------------------
  hdc_pkg::im_beat_t im_a;
  hdc_pkg::im_beat_t im_b;

  item_mem_port u_im_a (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .valid_i  ( req_i.valid  ),
    .cim_i    ( req_i.cim_a  ),
    .addr_i   ( req_i.addr_a ),
    .beat_o   ( im_a         )
  );

  item_mem_port u_im_b (
    .clk_i    ( clk_i        ),
    .arst_n_i ( arst_n_i     ),
    .valid_i  ( req_i.valid  ),
    .cim_i    ( req_i.cim_b  ),
    .addr_i   ( req_i.addr_b ),
    .beat_o   ( im_b         )
  );

  // -------------------------------------------------------------------
  // Bind and bundle
  // -------------------------------------------------------------------
  // Request strobes are realigned inside the bundler
  hv_bundler u_bundler (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .valid_i     ( req_i.valid ),
    .last_i      ( req_i.last  ),
    .im_a_i      ( im_a        ),
    .im_b_i      ( im_b        ),
    .qhv_o       ( qhv_o       ),
    .qhv_valid_o ( qhv_valid_o )
  );

endmodule

`default_nettype wire

//--- verilog/hv_bundler.sv
`default_nettype none

module hv_bundler (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  input  logic              last_i,
  input  hdc_pkg::im_beat_t im_a_i,
  input  hdc_pkg::im_beat_t im_b_i,
  output hdc_pkg::hv_t      qhv_o,
  output logic              qhv_valid_o
);

  // -------------------------------------------------------------------
  // Request alignment with the item memory stage
  // -------------------------------------------------------------------
  logic valid_q;
  logic last_q;
  logic acc_en;
  logic close;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else begin
      valid_q <= valid_i;
      last_q  <= last_i;
    end
  end

  assign acc_en = valid_q;
  assign close  = valid_q & last_q;

  // -------------------------------------------------------------------
  // Bind and accumulate
  // -------------------------------------------------------------------
  hdc_pkg::hv_t                                           bound;
  logic [hdc_pkg::HV_DIM-1:0][hdc_pkg::BUND_CNT_W-1:0]    cnt_q;
  logic [hdc_pkg::HV_DIM-1:0][hdc_pkg::BUND_CNT_W-1:0]    cnt_d;
  logic [hdc_pkg::BUND_CNT_W-1:0]                         beat_q;
  logic [hdc_pkg::BUND_CNT_W-1:0]                         beat_d;
  hdc_pkg::hv_t                                           qhv_d;

  assign bound  = im_a_i.hv ^ im_b_i.hv;
  assign beat_d = beat_q + {{(hdc_pkg::BUND_CNT_W-1){1'b0}}, 1'b1};

  // Counts include the current beat, so majority sees it too
  always_comb begin
    for (int i = 0; i < hdc_pkg::HV_DIM; i++) begin
      cnt_d[i] = cnt_q[i] + {{(hdc_pkg::BUND_CNT_W-1){1'b0}}, bound[i]};
      // 2*count > beats, a tie stays 0
      qhv_d[i] = {cnt_d[i], 1'b0} > {1'b0, beat_d};
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= '0;
      beat_q <= '0;
    end else if (close) begin
      // Next bundle starts from zero
      cnt_q  <= '0;
      beat_q <= '0;
    end else if (acc_en) begin
      cnt_q  <= cnt_d;
      beat_q <= beat_d;
    end
  end

  // -------------------------------------------------------------------
  // Query HV output
  // -------------------------------------------------------------------
  hdc_pkg::hv_t qhv_q;
  logic         qhv_valid_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      qhv_valid_q <= 1'b0;
    end else begin
      qhv_valid_q <= close;
    end
  end

  always_ff @(posedge clk_i) begin
    if (close) begin
      qhv_q <= qhv_d;
    end
  end

  assign qhv_o       = qhv_q;
  assign qhv_valid_o = qhv_valid_q;

  // Both ports and the delayed request must stay in lockstep
  a_ports_aligned : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (im_a_i.valid == im_b_i.valid) && (im_a_i.valid == valid_q)
  ) else $error("hv_bundler: port beats out of step");

  // At most 255 beats per bundle
  a_no_beat_wrap : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    acc_en |-> (beat_q != '1)
  ) else $error("hv_bundler: beat counter overflow");

endmodule

`default_nettype wire
